// ==== ssm_pkg.sv ====
// ssm tile engine shared definitions
// signed q8.8 fixed point widths, tile sizes, tile structs
// and the wrapping fixed point multiply used by every stage

package ssm_pkg;

    // ============================================================
    // fixed point format
    // ============================================================
    localparam int DATA_W = 16;
    localparam int FRAC_W = 8;

    // one fixed point value
    typedef logic signed [DATA_W-1:0] fx_t;

    // 1.0 in q8.8
    localparam fx_t ONE = fx_t'(1 << FRAC_W);

    // ============================================================
    // tile sizes
    // ============================================================
    // x channels per tile
    localparam int P_TILE = 2;
    // state lanes per tile
    localparam int N_TILE = 4;

    // per channel vector
    typedef fx_t [P_TILE-1:0] fx_p_t;
    // per lane vector
    typedef fx_t [N_TILE-1:0] fx_n_t;
    // state matrix, indexed [p][n]
    typedef fx_t [P_TILE-1:0][N_TILE-1:0] fx_pn_t;

    // ============================================================
    // tile structs
    // ============================================================
    // raw tile as it enters the engine
    typedef struct packed {
        fx_t    dt;
        fx_t    dt_bias;
        fx_t    a;
        fx_t    d;
        fx_p_t  x;
        fx_n_t  b;
        fx_n_t  c;
        fx_pn_t hprev;
    } tile_in_t;

    // discretized tile, b c and hprev carried unchanged
    typedef struct packed {
        fx_t    da;
        fx_p_t  dx;
        fx_p_t  xd;
        fx_n_t  b;
        fx_n_t  c;
        fx_pn_t hprev;
    } disc_t;

    // ============================================================
    // arithmetic
    // ============================================================
    // full signed product, arithmetic shift by FRAC_W,
    // then wrap to DATA_W bits
    function automatic fx_t fx_mul(input fx_t lhs, input fx_t rhs);
        logic signed [2*DATA_W-1:0] prod;
        logic signed [2*DATA_W-1:0] shifted;
        prod    = lhs * rhs;
        shifted = prod >>> FRAC_W;
        return shifted[DATA_W-1:0];
    endfunction

endpackage

// ==== ssm_discretize.sv ====
// ssm discretize stage
// two cycle pipeline from raw tile scalars to dA, dx and xD
// delta is clamped by relu, dA uses the first order exp form

`timescale 1ns/1ps

module ssm_discretize (
    input  logic              clk,
    input  logic              rstn,
    input  logic              tile_valid_i,
    input  ssm_pkg::tile_in_t tile_i,
    output logic              disc_valid_o,
    output ssm_pkg::disc_t    disc_o
);

    import ssm_pkg::*;

    // stage 0 combinational
    fx_t      delta;
    fx_t      delta_sp;

    // stage 1 registers
    logic     s1_valid;
    tile_in_t s1_tile;
    fx_t      s1_delta_sp;

    // stage 2 next value
    disc_t    disc_next;

    // ============================================================
    // stage 1  delta and relu
    // ============================================================
    // wrapping add of dt and its bias
    assign delta = tile_i.dt + tile_i.dt_bias;

    // relu stands in for softplus
    // negative delta -> zero step
    assign delta_sp = delta[DATA_W-1] ? fx_t'(0) : delta;

    // valid pipe
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid     <= 1'b0;
            disc_valid_o <= 1'b0;
        end else begin
            s1_valid     <= tile_valid_i;
            disc_valid_o <= s1_valid;
        end
    end

    // tile rides along with delta_sp
    always_ff @(posedge clk) begin
        if (tile_valid_i) begin
            s1_tile     <= tile_i;
            s1_delta_sp <= delta_sp;
        end
    end

    // ============================================================
    // stage 2  dA, dx, xD
    // ============================================================
    always_comb begin
        // first order exp, 1 + delta_sp*A
        disc_next.da = ONE + fx_mul(s1_delta_sp, s1_tile.a);

        // per channel input scaling
        for (int p = 0; p < P_TILE; p++) begin
            disc_next.dx[p] = fx_mul(s1_delta_sp, s1_tile.x[p]);
            // skip term, used once per group downstream
            disc_next.xd[p] = fx_mul(s1_tile.x[p], s1_tile.d);
        end

        // lane data passes straight through
        disc_next.b     = s1_tile.b;
        disc_next.c     = s1_tile.c;
        disc_next.hprev = s1_tile.hprev;
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            disc_o <= disc_next;
        end
    end

    // ============================================================
    // checks
    // ============================================================
    // fixed two cycle latency, no stalls anywhere
    a_disc_latency : assert property (
        @(posedge clk) disable iff (!rstn)
        disc_valid_o == $past(tile_valid_i, 2)
    ) else $error("disc_valid_o out of step with tile_valid_i");

endmodule

// ==== ssm_state_update.sv ====
// ssm state update stage
// next state per (p, n) pair, C projection and lane reduction
// two cycle pipeline, xD rides along to the group stage

`timescale 1ns/1ps

module ssm_state_update (
    input  logic            clk,
    input  logic            rstn,
    input  logic            disc_valid_i,
    input  ssm_pkg::disc_t  disc_i,
    output logic            sum_valid_o,
    output ssm_pkg::fx_p_t  tile_sum_o,
    output ssm_pkg::fx_p_t  xd_o
);

    import ssm_pkg::*;

    // combinational next state
    fx_pn_t hnext;

    // stage 1 registers
    logic   s1_valid;
    fx_pn_t s1_hnext;
    fx_n_t  s1_c;
    fx_p_t  s1_xd;

    // combinational lane reduction
    fx_p_t  lane_sum;

    // ============================================================
    // stage 1  h_next = dA*hprev + dx*B
    // ============================================================
    always_comb begin
        for (int p = 0; p < P_TILE; p++) begin
            for (int n = 0; n < N_TILE; n++) begin
                // dA shared by all pairs, dx per channel, B per lane
                hnext[p][n] = fx_mul(disc_i.da, disc_i.hprev[p][n])
                            + fx_mul(disc_i.dx[p], disc_i.b[n]);
            end
        end
    end

    // valid pipe
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid    <= 1'b0;
            sum_valid_o <= 1'b0;
        end else begin
            s1_valid    <= disc_valid_i;
            sum_valid_o <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (disc_valid_i) begin
            s1_hnext <= hnext;
            // C only needed one stage later
            s1_c     <= disc_i.c;
            s1_xd    <= disc_i.xd;
        end
    end

    // ============================================================
    // stage 2  sum over lanes of h_next*C
    // ============================================================
    always_comb begin
        for (int p = 0; p < P_TILE; p++) begin
            lane_sum[p] = '0;
            // element wise add, each channel wraps on its own
            for (int n = 0; n < N_TILE; n++) begin
                lane_sum[p] = lane_sum[p] + fx_mul(s1_hnext[p][n], s1_c[n]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            tile_sum_o <= lane_sum;
            xd_o       <= s1_xd;
        end
    end

    // ============================================================
    // checks
    // ============================================================
    // valid chain must be clean once out of reset
    a_sum_valid_known : assert property (
        @(posedge clk) disable iff (!rstn)
        !$isunknown(sum_valid_o)
    ) else $error("sum_valid_o unknown after reset");

endmodule

// ==== ssm_group_accum.sv ====
// ssm group accumulator
// sums the per tile partials over TILES_PER_GROUP tiles,
// adds the xD term of the group's first tile on the last tile
// and emits y with a single cycle valid

`timescale 1ns/1ps

module ssm_group_accum #(
    parameter int TILES_PER_GROUP = 4
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic            sum_valid_i,
    input  ssm_pkg::fx_p_t  tile_sum_i,
    input  ssm_pkg::fx_p_t  xd_i,
    output logic            y_valid_o,
    output ssm_pkg::fx_p_t  y_o
);

    import ssm_pkg::*;

    // at least one bit even for single tile groups
    localparam int CNT_W = (TILES_PER_GROUP > 1) ? $clog2(TILES_PER_GROUP) : 1;

    // tile position inside the group
    logic [CNT_W-1:0] tile_cnt;
    logic             first_tile;
    logic             last_tile;

    // running partial sum and held skip term
    fx_p_t            acc;
    fx_p_t            xd_hold;

    // combinational next values
    fx_p_t            acc_base;
    fx_p_t            xd_sel;
    fx_p_t            acc_next;
    fx_p_t            y_next;

    // ============================================================
    // tile counter
    // ============================================================
    assign first_tile = (tile_cnt == '0);
    assign last_tile  = (tile_cnt == CNT_W'(TILES_PER_GROUP - 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tile_cnt <= '0;
        end else if (sum_valid_i) begin
            // wrap at group end
            if (last_tile) begin
                tile_cnt <= '0;
            end else begin
                tile_cnt <= tile_cnt + 1'b1;
            end
        end
    end

    // ============================================================
    // accumulate and final add
    // ============================================================
    // first tile starts from zero and uses its own xD
    assign acc_base = first_tile ? fx_p_t'(0) : acc;
    assign xd_sel   = first_tile ? xd_i : xd_hold;

    always_comb begin
        // per channel, each wraps at DATA_W
        for (int p = 0; p < P_TILE; p++) begin
            acc_next[p] = acc_base[p] + tile_sum_i[p];
            y_next[p]   = acc_next[p] + xd_sel[p];
        end
    end

    always_ff @(posedge clk) begin
        if (sum_valid_i) begin
            acc <= acc_next;
            if (first_tile) begin
                xd_hold <= xd_i;
            end
            if (last_tile) begin
                y_o <= y_next;
            end
        end
    end

    // one pulse per group
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            y_valid_o <= 1'b0;
        end else begin
            y_valid_o <= sum_valid_i && last_tile;
        end
    end

    // ============================================================
    // checks
    // ============================================================
    a_cnt_range : assert property (
        @(posedge clk) disable iff (!rstn)
        int'(tile_cnt) < TILES_PER_GROUP
    ) else $error("tile counter out of range");

    // back to back y only possible with single tile groups
    a_y_single_pulse : assert property (
        @(posedge clk) disable iff (!rstn)
        (y_valid_o && (TILES_PER_GROUP > 1)) |=> !y_valid_o
    ) else $error("y_valid_o high on consecutive cycles");

endmodule

// ==== ssm_block_top.sv ====
// ssm block top level
// discretize -> state update -> group accumulate
// tile in on tile_valid_i, y out five cycles after a group's last tile

`timescale 1ns/1ps

module ssm_block_top #(
    parameter int TILES_PER_GROUP = 4
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              tile_valid_i,
    input  ssm_pkg::tile_in_t tile_i,
    output logic              y_valid_o,
    output ssm_pkg::fx_p_t    y_o
);

    import ssm_pkg::*;

    // ============================================================
    // inter stage wires
    // ============================================================
    // discretize -> state update
    logic  disc_valid;
    disc_t disc;

    // state update -> group accumulate
    logic  sum_valid;
    fx_p_t tile_sum;
    fx_p_t xd;

    // ============================================================
    // stages
    // ============================================================
    // 2 cycles, delta_sp then dA dx xD
    ssm_discretize u_discretize (
        .clk          (clk),
        .rstn         (rstn),
        .tile_valid_i (tile_valid_i),
        .tile_i       (tile_i),
        .disc_valid_o (disc_valid),
        .disc_o       (disc)
    );

    // 2 cycles, h_next then lane sum of h_next*C
    ssm_state_update u_state_update (
        .clk          (clk),
        .rstn         (rstn),
        .disc_valid_i (disc_valid),
        .disc_i       (disc),
        .sum_valid_o  (sum_valid),
        .tile_sum_o   (tile_sum),
        .xd_o         (xd)
    );

    // 1 cycle after the last tile of a group
    ssm_group_accum #(
        .TILES_PER_GROUP (TILES_PER_GROUP)
    ) u_group_accum (
        .clk          (clk),
        .rstn         (rstn),
        .sum_valid_i  (sum_valid),
        .tile_sum_i   (tile_sum),
        .xd_i         (xd),
        .y_valid_o    (y_valid_o),
        .y_o          (y_o)
    );

endmodule

// ==== tb_clock_gen.sv ====
// testbench clock and reset source
// free running clock, active low reset held for a set number of cycles

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter realtime PERIOD_NS    = 100.0,
    parameter int      RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #(PERIOD_NS / 2.0);
        rstn_o = 1'b1;
    end

endmodule

// ==== tb_ssm_block.sv ====
// ssm block testbench
// directed and random tile groups, integer reference model,
// output checker on y_valid_o and a watchdog

`timescale 1ns/1ps

module tb_ssm_block;

    import ssm_pkg::*;

    // ============================================================
    // test setup
    // ============================================================
    localparam int          TILES_PER_GROUP = 4;
    localparam realtime     CLK_PERIOD      = 100.0;
    localparam realtime     STIM_DELAY      = 5.0;
    localparam logic [31:0] SEED            = 32'd60179;
    localparam int          N_B2B           = 6;
    localparam int          N_GAP           = 6;
    localparam int          MAX_GAP         = 4;
    // two directed groups up front
    localparam int          NUM_GROUPS      = 2 + N_B2B + N_GAP;
    localparam int          TIMEOUT_CYCLES  =
        NUM_GROUPS * TILES_PER_GROUP * (MAX_GAP + 1) + 100;

    typedef tile_in_t group_t [TILES_PER_GROUP];

    logic     clk;
    logic     rstn;
    logic     tile_valid_i;
    tile_in_t tile_i;
    logic     y_valid_o;
    fx_p_t    y_o;

    // expected y and the edge its last tile was driven after
    fx_p_t       exp_y_q[$];
    int          exp_edge_q[$];
    int          edge_cnt  = 0;
    int          pulse_cnt = 0;
    logic [31:0] lcg_state = SEED;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (10)
    ) u_clock_gen (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    ssm_block_top #(
        .TILES_PER_GROUP (TILES_PER_GROUP)
    ) u_dut (
        .clk          (clk),
        .rstn         (rstn),
        .tile_valid_i (tile_valid_i),
        .tile_i       (tile_i),
        .y_valid_o    (y_valid_o),
        .y_o          (y_o)
    );

    // ============================================================
    // random numbers and reference model
    // ============================================================
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic fx_t rand_fx();
        lcg_state = lcg_next(lcg_state);
        return fx_t'(lcg_state[31:16]);
    endfunction

    function automatic int rand_range(input int n);
        lcg_state = lcg_next(lcg_state);
        return int'(lcg_state[30:16]) % n;
    endfunction

    function automatic int sx(input logic [DATA_W-1:0] v);
        return int'($signed(v));
    endfunction

    // two's complement wrap to DATA_W bits
    function automatic int wrap16(input longint v);
        logic [DATA_W-1:0] low;
        low = v[DATA_W-1:0];
        return sx(low);
    endfunction

    // full product, arithmetic shift, wrap
    function automatic int ref_mul(input int a, input int b);
        longint prod;
        prod = longint'(a) * longint'(b);
        return wrap16(prod >>> FRAC_W);
    endfunction

    // y for one group, straight from the tile equations
    function automatic fx_p_t ref_group(input group_t g);
        int    acc [P_TILE];
        int    delta;
        int    dsp;
        int    da;
        int    dx;
        int    h;
        fx_p_t y;
        for (int p = 0; p < P_TILE; p++) acc[p] = 0;
        for (int t = 0; t < TILES_PER_GROUP; t++) begin
            delta = wrap16(sx(g[t].dt) + sx(g[t].dt_bias));
            // relu
            dsp   = (delta < 0) ? 0 : delta;
            da    = wrap16((1 << FRAC_W) + ref_mul(dsp, sx(g[t].a)));
            for (int p = 0; p < P_TILE; p++) begin
                dx = ref_mul(dsp, sx(g[t].x[p]));
                for (int n = 0; n < N_TILE; n++) begin
                    h      = wrap16(ref_mul(da, sx(g[t].hprev[p][n]))
                                    + ref_mul(dx, sx(g[t].b[n])));
                    acc[p] = wrap16(acc[p] + ref_mul(h, sx(g[t].c[n])));
                end
            end
        end
        // skip term from the first tile only
        for (int p = 0; p < P_TILE; p++) begin
            y[p] = fx_t'(wrap16(acc[p] + ref_mul(sx(g[0].x[p]), sx(g[0].d))));
        end
        return y;
    endfunction

    // ============================================================
    // compare and stimulus tasks
    // ============================================================
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #STIM_DELAY;
        end
    endtask

    task automatic drive_tile(input tile_in_t t);
        tile_i       = t;
        tile_valid_i = 1'b1;
        @(posedge clk);
        #STIM_DELAY;
        tile_valid_i = 1'b0;
    endtask

    // kind 0 zero dt/B/hprev, kind 1 negative delta, kind 2 random
    task automatic run_group(input int kind, input int max_gap);
        group_t g;
        fx_p_t  x;
        fx_t    d;
        for (int p = 0; p < P_TILE; p++) x[p] = rand_fx();
        d = rand_fx();
        for (int t = 0; t < TILES_PER_GROUP; t++) begin
            g[t].dt      = rand_fx();
            g[t].dt_bias = rand_fx();
            g[t].a       = rand_fx();
            g[t].d       = d;
            g[t].x       = x;
            for (int n = 0; n < N_TILE; n++) begin
                g[t].b[n] = rand_fx();
                g[t].c[n] = rand_fx();
                for (int p = 0; p < P_TILE; p++) g[t].hprev[p][n] = rand_fx();
            end
            if (kind == 0) begin
                g[t].dt    = '0;
                g[t].b     = '0;
                g[t].hprev = '0;
            end else if (kind == 1) begin
                // -2.0 + -1.0, clearly below zero
                g[t].dt      = -fx_t'(512);
                g[t].dt_bias = -fx_t'(256);
            end
        end
        exp_y_q.push_back(ref_group(g));
        for (int t = 0; t < TILES_PER_GROUP; t++) begin
            if (max_gap > 0) idle(rand_range(max_gap + 1));
            if (t == TILES_PER_GROUP - 1) exp_edge_q.push_back(edge_cnt);
            drive_tile(g[t]);
        end
    endtask

    // ============================================================
    // checker, watchdog and main sequence
    // ============================================================
    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    // outputs settled by the falling edge
    always @(negedge clk) begin
        if (rstn && y_valid_o) begin
            if (exp_y_q.size() == 0) begin
                $display("y_valid_o pulsed at %0t ns with no group outstanding", $time);
                $display("TEST FAIL");
                $fatal(1, "unexpected output pulse");
            end else begin
                check_value("y_o", y_o, exp_y_q.pop_front());
                check_value("y_valid_o latency", edge_cnt - exp_edge_q.pop_front(), 5);
                pulse_cnt++;
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        tile_valid_i = 1'b0;
        tile_i       = '0;
        @(posedge rstn);
        // quiet period, any y pulse here is flagged by the checker
        idle(8);
        run_group(0, 0);
        run_group(1, 0);
        repeat (N_B2B) run_group(2, 0);
        repeat (N_GAP) run_group(2, MAX_GAP);
        // last y due five edges after the final tile
        idle(10);
        check_value("y_valid_o pulse count", pulse_cnt, NUM_GROUPS);
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== filelist.f ====
ssm_pkg.sv
ssm_discretize.sv
ssm_state_update.sv
ssm_group_accum.sv
ssm_block_top.sv
tb_clock_gen.sv
tb_ssm_block.sv

// ==== Makefile ====
# Verilator build and run for the ssm tile engine testbench

VERILATOR ?= verilator
TOP       ?= tb_ssm_block
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS      := $(shell cat $(FILELIST))
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf $(OBJ_DIR)
